// File: hdl/mul_cfg_pkg.sv
package mul_cfg_pkg;

	// operand and product geometry
	localparam int OP_W   = 16;
	localparam int PROD_W = 32;
	localparam int ROW_W  = 17;
	localparam int N_ROWS = 8;
	localparam int TAG_W  = 3;

	// flow control
	localparam int REQ_CREDITS  = 4;
	localparam int RESULT_DEPTH = 4;
	localparam int RES_CREDITS  = 2;

	// queue pointer, occupancy and credit counter widths
	localparam int QPTR_W = $clog2(RESULT_DEPTH);
	localparam int QCNT_W = $clog2(RESULT_DEPTH + 1);
	localparam int CRED_W = $clog2(RES_CREDITS + 1);

	// minus the sum of 2^(17+2i) over all rows, mod 2^32
	// pairs with the inverted row sign bits
	localparam logic [PROD_W-1:0] SE_CONST = 32'h5556_0000;

endpackage

// File: hdl/mul_types_pkg.sv
package mul_types_pkg;

	import mul_cfg_pkg::*;

	// first letter is a (multiplicand), second is b (multiplier)
	typedef enum logic [1:0] {
		MODE_UU = 2'd0,
		MODE_US = 2'd1,
		MODE_SU = 2'd2,
		MODE_SS = 2'd3
	} mul_mode_e;

	typedef struct packed {
		logic [OP_W-1:0]  a;
		logic [OP_W-1:0]  b;
		mul_mode_e        mode;
		logic [TAG_W-1:0] tag;
	} mul_req_t;

	typedef struct packed {
		logic             valid;
		logic [ROW_W-1:0] mcand_ext;
		logic [ROW_W-1:0] mlier_ext;
		logic [OP_W-1:0]  corr_row;
		logic             sign_out;
		logic [TAG_W-1:0] tag;
	} mul_operand_t;

	typedef struct packed {
		logic [ROW_W-1:0] pp;
		logic             neg;
		logic             sign;
	} pp_row_t;

	typedef struct packed {
		logic [PROD_W-1:0] prod;
		logic              sign_out;
		logic [TAG_W-1:0]  tag;
	} mul_result_t;

endpackage

// File: hdl/mul_req_intake.sv
`timescale 1ns/1ns

module mul_req_intake (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        req_valid,
	input  mul_types_pkg::mul_req_t     req,
	output mul_types_pkg::mul_operand_t opnd
);

	import mul_cfg_pkg::*;
	import mul_types_pkg::*;

	mul_operand_t opnd_d;
	mul_operand_t opnd_q;
	logic         valid_q;
	logic         a_unsigned;
	logic         b_unsigned;
	logic         any_zero;

	//----------------------------------------------------------------------
	// operand preparation
	//----------------------------------------------------------------------
	assign a_unsigned = (req.mode == MODE_UU) || (req.mode == MODE_US);
	assign b_unsigned = (req.mode == MODE_UU) || (req.mode == MODE_SU);
	assign any_zero   = (req.a == '0) || (req.b == '0);

	always_comb begin
		opnd_d.valid = req_valid;
		opnd_d.tag   = req.tag;

		if (a_unsigned) begin
			opnd_d.mcand_ext = {1'b0, req.a};
		end else begin
			opnd_d.mcand_ext = {req.a[OP_W-1], req.a};
		end

		// booth window 0 sees an implied zero below b[0]
		opnd_d.mlier_ext = {req.b, 1'b0};

		// booth reads b as signed, so an unsigned b with msb set is short by a*2^16
		if (b_unsigned && req.b[OP_W-1]) begin
			opnd_d.corr_row = req.a;
		end else begin
			opnd_d.corr_row = '0;
		end

		if (any_zero) begin
			opnd_d.sign_out = 1'b0;
		end else begin
			case (req.mode)
				MODE_SS: opnd_d.sign_out = req.a[OP_W-1] ^ req.b[OP_W-1];
				MODE_SU: opnd_d.sign_out = req.a[OP_W-1];
				MODE_US: opnd_d.sign_out = req.b[OP_W-1];
				default: opnd_d.sign_out = 1'b0;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// request register
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= opnd_d.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			opnd_q <= opnd_d;
		end
	end

	always_comb begin
		opnd       = opnd_q;
		opnd.valid = valid_q;
	end

endmodule

// File: hdl/booth_pp_gen.sv
`timescale 1ns/1ns

module booth_pp_gen (
	input  logic [16:0]            mcand,
	input  logic [2:0]             window,
	output mul_types_pkg::pp_row_t row
);

	import mul_cfg_pkg::*;

	logic             sel_one;
	logic             sel_two;
	logic             neg;
	logic [ROW_W-1:0] mag;
	logic             mag_sign;

	// radix-4 recode of {b[2i+1], b[2i], b[2i-1]}
	always_comb begin
		sel_one = 1'b0;
		sel_two = 1'b0;
		neg     = 1'b0;
		case (window)
			3'b001, 3'b010: sel_one = 1'b1;
			3'b011: sel_two = 1'b1;
			3'b100: begin
				sel_two = 1'b1;
				neg     = 1'b1;
			end
			3'b101, 3'b110: begin
				sel_one = 1'b1;
				neg     = 1'b1;
			end
			default: ;
		endcase
	end

	// 2x shifts left, the sign stays that of the extended multiplicand
	always_comb begin
		if (sel_one) begin
			mag = mcand;
		end else if (sel_two) begin
			mag = {mcand[ROW_W-2:0], 1'b0};
		end else begin
			mag = '0;
		end
		mag_sign = (sel_one || sel_two) ? mcand[ROW_W-1] : 1'b0;
	end

	// ones complement here, the +1 is added in the reduction
	always_comb begin
		row.pp   = neg ? ~mag : mag;
		row.sign = neg ? ~mag_sign : mag_sign;
		row.neg  = neg;
	end

endmodule

// File: hdl/pp_reduce.sv
`timescale 1ns/1ns

module pp_reduce (
	input  logic                                        clk,
	input  logic                                        arst_n,
	input  mul_types_pkg::mul_operand_t                 opnd,
	input  mul_types_pkg::pp_row_t [mul_cfg_pkg::N_ROWS-1:0] rows,
	output logic                                        out_valid,
	output mul_types_pkg::mul_result_t                  result
);

	import mul_cfg_pkg::*;

	logic [PROD_W-1:0] row_vec [N_ROWS];
	logic [PROD_W-1:0] extra_vec;
	logic [PROD_W-1:0] acc_s;
	logic [PROD_W-1:0] acc_c;
	logic [PROD_W-1:0] nxt_s;

	logic              s1_valid;
	logic [PROD_W-1:0] s1_sum;
	logic [PROD_W-1:0] s1_carry;
	logic              s1_sign;
	logic [TAG_W-1:0]  s1_tag;

	function automatic logic [PROD_W-1:0] csa_sum(
		input logic [PROD_W-1:0] x,
		input logic [PROD_W-1:0] y,
		input logic [PROD_W-1:0] z
	);
		return x ^ y ^ z;
	endfunction

	// majority shifted up one column, top carry drops out mod 2^32
	function automatic logic [PROD_W-1:0] csa_carry(
		input logic [PROD_W-1:0] x,
		input logic [PROD_W-1:0] y,
		input logic [PROD_W-1:0] z
	);
		return ((x & y) | (x & z) | (y & z)) << 1;
	endfunction

	//----------------------------------------------------------------------
	// stage 1: row alignment and carry-save compression
	//----------------------------------------------------------------------
	always_comb begin
		// neg bits sit at even columns below 16, constant bits start at 17
		extra_vec = SE_CONST;
		for (int i = 0; i < N_ROWS; i++) begin
			row_vec[i]     = PROD_W'({~rows[i].sign, rows[i].pp}) << (2 * i);
			extra_vec[2*i] = rows[i].neg;
		end

		acc_s = extra_vec;
		acc_c = {opnd.corr_row, {OP_W{1'b0}}};
		nxt_s = '0;
		// one 3:2 level per row
		for (int i = 0; i < N_ROWS; i++) begin
			nxt_s = csa_sum(acc_s, acc_c, row_vec[i]);
			acc_c = csa_carry(acc_s, acc_c, row_vec[i]);
			acc_s = nxt_s;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= opnd.valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_sum   <= acc_s;
		s1_carry <= acc_c;
		s1_sign  <= opnd.sign_out;
		s1_tag   <= opnd.tag;
	end

	//----------------------------------------------------------------------
	// stage 2: carry-propagate add
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		result.prod     <= s1_sum + s1_carry;
		result.sign_out <= s1_sign;
		result.tag      <= s1_tag;
	end

endmodule

// File: hdl/mul_result_queue.sv
`timescale 1ns/1ns

module mul_result_queue (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       in_valid,
	input  mul_types_pkg::mul_result_t in_result,
	input  logic                       res_credit,
	output logic                       res_valid,
	output mul_types_pkg::mul_result_t res,
	output logic                       req_credit
);

	import mul_cfg_pkg::*;
	import mul_types_pkg::*;

	mul_result_t       mem [RESULT_DEPTH];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QCNT_W-1:0] count;
	logic [CRED_W-1:0] credits;
	logic              q_empty;
	logic              pop;
	mul_result_t       head;

	// empty queue passes the incoming result straight to the output
	always_comb begin
		q_empty = (count == '0);
		head    = q_empty ? in_result : mem[rd_ptr];
		pop     = (!q_empty || in_valid) && (credits != '0);
	end

	//----------------------------------------------------------------------
	// storage
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_result;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			res <= head;
		end
	end

	//----------------------------------------------------------------------
	// pointers, occupancy and credits
	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credits    <= CRED_W'(RES_CREDITS);
			res_valid  <= 1'b0;
			req_credit <= 1'b0;
		end else begin
			if (in_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count      <= count + QCNT_W'(in_valid) - QCNT_W'(pop);
			// pop and credit return may land together
			credits    <= credits + CRED_W'(res_credit) - CRED_W'(pop);
			res_valid  <= pop;
			req_credit <= pop;
		end
	end

endmodule

// File: hdl/booth_mul_top.sv
`timescale 1ns/1ns

module booth_mul_top (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       req_valid,
	input  mul_types_pkg::mul_req_t    req,
	output logic                       req_credit,
	output logic                       res_valid,
	output mul_types_pkg::mul_result_t res,
	input  logic                       res_credit
);

	import mul_cfg_pkg::*;
	import mul_types_pkg::*;

	mul_operand_t             opnd;
	pp_row_t [N_ROWS-1:0]     rows;
	logic                     red_valid;
	mul_result_t              red_result;

	mul_req_intake u_intake (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req       (req),
		.opnd      (opnd)
	);

	//----------------------------------------------------------------------
	// booth rows, window i covers mlier_ext[2i+2:2i]
	//----------------------------------------------------------------------
	for (genvar i = 0; i < N_ROWS; i++) begin : g_row
		booth_pp_gen u_pp (
			.mcand  (opnd.mcand_ext),
			.window (opnd.mlier_ext[2*i+2:2*i]),
			.row    (rows[i])
		);
	end

	pp_reduce u_reduce (
		.clk       (clk),
		.arst_n    (arst_n),
		.opnd      (opnd),
		.rows      (rows),
		.out_valid (red_valid),
		.result    (red_result)
	);

	mul_result_queue u_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (red_valid),
		.in_result  (red_result),
		.res_credit (res_credit),
		.res_valid  (res_valid),
		.res        (res),
		.req_credit (req_credit)
	);

endmodule

// File: verif/booth_mul_properties.sv
`timescale 1ns/1ns

module booth_mul_properties (
	input logic                       clk,
	input logic                       arst_n,
	input logic                       req_valid,
	input mul_types_pkg::mul_req_t    req,
	input logic                       req_credit,
	input logic                       res_valid,
	input mul_types_pkg::mul_result_t res,
	input logic                       res_credit
);

	import mul_cfg_pkg::*;
	import mul_types_pkg::*;

	int                fail_count = 0;
	int                outstanding;
	int                res_cred;
	logic [OP_W-1:0]   op_a [2**TAG_W];
	logic [OP_W-1:0]   op_b [2**TAG_W];
	mul_mode_e         op_mode [2**TAG_W];
	logic [OP_W-1:0]   cur_a;
	logic [OP_W-1:0]   cur_b;
	logic              a_sgn;
	logic              b_sgn;
	logic [PROD_W-1:0] ext_a;
	logic [PROD_W-1:0] ext_b;
	logic [PROD_W-1:0] want_prod;
	logic              want_sign;

	// operands held by tag until their result leaves
	always_ff @(posedge clk) begin
		if (req_valid) begin
			op_a[req.tag]    <= req.a;
			op_b[req.tag]    <= req.b;
			op_mode[req.tag] <= req.mode;
		end
	end

	// requests in flight and result credits seen from outside
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			outstanding <= 0;
			res_cred    <= RES_CREDITS;
		end else begin
			outstanding <= outstanding + int'(req_valid) - int'(req_credit);
			res_cred    <= res_cred + int'(res_credit) - int'(res_valid);
		end
	end

	//----------------------------------------------------------------------
	// reference product for the result at the output
	//----------------------------------------------------------------------
	always_comb begin
		cur_a     = op_a[res.tag];
		cur_b     = op_b[res.tag];
		a_sgn     = (op_mode[res.tag] == MODE_SU) || (op_mode[res.tag] == MODE_SS);
		b_sgn     = (op_mode[res.tag] == MODE_US) || (op_mode[res.tag] == MODE_SS);
		ext_a     = {{OP_W{a_sgn & cur_a[OP_W-1]}}, cur_a};
		ext_b     = {{OP_W{b_sgn & cur_b[OP_W-1]}}, cur_b};
		want_prod = ext_a * ext_b;
		want_sign = (cur_a != '0) && (cur_b != '0) &&
			((a_sgn & cur_a[OP_W-1]) ^ (b_sgn & cur_b[OP_W-1]));
	end

	a_prod: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> (res.prod == want_prod))
		else begin
			$error("product wrong for tag %0d", res.tag);
			fail_count++;
		end

	a_sign: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> (res.sign_out == want_sign))
		else begin
			$error("sign flag wrong for tag %0d", res.tag);
			fail_count++;
		end

	a_res_credit: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> (res_cred > 0))
		else begin
			$error("result sent without a result credit");
			fail_count++;
		end

	// a credit returned with nothing in flight drives the count below zero
	a_req_credit: assert property (@(posedge clk) disable iff (!arst_n)
		(outstanding >= 0) && (outstanding <= REQ_CREDITS))
		else begin
			$error("request credits returned or spent beyond the request credit limit");
			fail_count++;
		end

	a_reset: assert property (@(posedge clk)
		!arst_n |-> (!res_valid && !req_credit))
		else begin
			$error("output pulse while reset is held");
			fail_count++;
		end

endmodule

bind booth_mul_top booth_mul_properties u_props (
	.clk        (clk),
	.arst_n     (arst_n),
	.req_valid  (req_valid),
	.req        (req),
	.req_credit (req_credit),
	.res_valid  (res_valid),
	.res        (res),
	.res_credit (res_credit)
);

// File: verif/tb_booth_mul.sv
`timescale 1ns/1ns

module tb_booth_mul;

	import mul_cfg_pkg::*;
	import mul_types_pkg::*;

	localparam int CLK_HALF = 20;
	localparam int RST_CYC  = 16;
	localparam int N_RANDOM = 200;
	// reset burst, corners, random, back-to-back, stall, exhaustion
	localparam int N_ISSUED = 3 + 100 + N_RANDOM + 4 + 4 + 6;

	logic        clk;
	logic        arst_n;
	logic        req_valid;
	mul_req_t    req;
	logic        req_credit;
	logic        res_valid;
	mul_result_t res;
	logic        res_credit = 1'b0;

	int          seed = 32'hd825;
	mul_result_t exp_q [$];
	string       test_name;
	logic        credit_next = 1'b0;
	logic        stall;
	logic        fast;
	int          req_cred;
	int          pending;
	int          n_issued;
	int          n_results;
	int          n_pulses;
	int          errors;
	int          n_tests;
	int          test_base;
	logic [15:0] corner [5] = '{16'h0000, 16'h0001, 16'h7fff, 16'h8000, 16'hffff};

	booth_mul_top i_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.res_valid  (res_valid),
		.res        (res),
		.res_credit (res_credit)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	initial begin
		#((RST_CYC + 200 * N_ISSUED) * 2 * CLK_HALF);
		$display("watchdog expired before all tests completed");
		$display("TEST FAIL");
		$finish;
	end

	// low 32 bits of the exact product, sign flag per mode
	function automatic mul_result_t expected(input mul_req_t r);
		logic        sa;
		logic        sb;
		logic [31:0] ea;
		logic [31:0] eb;
		mul_result_t e;
		sa         = (r.mode == MODE_SU) || (r.mode == MODE_SS);
		sb         = (r.mode == MODE_US) || (r.mode == MODE_SS);
		ea         = sa ? {{16{r.a[15]}}, r.a} : {16'h0000, r.a};
		eb         = sb ? {{16{r.b[15]}}, r.b} : {16'h0000, r.b};
		e.prod     = ea * eb;
		e.sign_out = (r.a != 16'h0) && (r.b != 16'h0) && ((sa & r.a[15]) ^ (sb & r.b[15]));
		e.tag      = r.tag;
		return e;
	endfunction

	//----------------------------------------------------------------------
	// result monitor and consumer credit model
	//----------------------------------------------------------------------
	always @(posedge clk) begin : monitor
		mul_result_t want;
		logic        give;
		if (res_valid) begin
			n_results++;
			pending++;
			if (exp_q.size() == 0) begin
				$display("result with tag %0d arrived with no request outstanding", res.tag);
				errors++;
			end else begin
				want = exp_q.pop_front();
				if (res !== want) begin
					$display("** Error %s: expected %h actual %h", test_name, want, res);
					errors++;
				end
			end
		end
		if (req_credit) begin
			req_cred++;
			n_pulses++;
		end
		give = 1'b0;
		if (!stall && pending > 0) begin
			give = fast || (($random(seed) & 1) == 0);
		end
		if (give) begin
			pending--;
		end
		credit_next <= give;
	end

	always @(negedge clk) begin
		res_credit <= credit_next;
	end

	//----------------------------------------------------------------------
	// stimulus tasks, called and returning on a falling edge
	//----------------------------------------------------------------------
	task automatic issue(input logic [15:0] a, input logic [15:0] b, input mul_mode_e mode);
		mul_req_t r;
		int       rnd;
		while (req_cred == 0) begin
			@(negedge clk);
		end
		rnd    = $random(seed);
		r.a    = a;
		r.b    = b;
		r.mode = mode;
		// low tag bits differ across any four requests in flight
		r.tag  = {rnd[0], n_issued[1:0]};
		req       = r;
		req_valid = 1'b1;
		req_cred--;
		n_issued++;
		exp_q.push_back(expected(r));
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic issue_random();
		logic [31:0] ab;
		logic [31:0] m;
		ab = $random(seed);
		m  = $random(seed);
		issue(ab[31:16], ab[15:0], mul_mode_e'(m[1:0]));
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0 || pending != 0 || credit_next || req_cred != REQ_CREDITS) begin
			@(negedge clk);
		end
	endtask

	task automatic check_count(input string what, input int want, input int got);
		if (want != got) begin
			$display("** Error %s: %s expected %0d actual %0d", test_name, what, want, got);
			errors++;
		end
	endtask

	// only RES_CREDITS results may leave while the consumer holds back
	task automatic stalled_burst(input int n);
		int base_res;
		int base_pulse;
		base_res   = n_results;
		base_pulse = n_pulses;
		stall      = 1'b1;
		for (int i = 0; i < n; i++) begin
			issue_random();
		end
		repeat (20) @(negedge clk);
		check_count("results under stall", RES_CREDITS, n_results - base_res);
		check_count("request credit pulses", n_results - base_res, n_pulses - base_pulse);
		check_count("request credits held", REQ_CREDITS - n + RES_CREDITS, req_cred);
		stall = 1'b0;
		wait_drain();
		check_count("results after drain", n, n_results - base_res);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_base = errors + i_dut.u_props.fail_count;
	endtask

	task automatic end_test();
		int now;
		now = errors + i_dut.u_props.fail_count;
		n_tests++;
		$display("%-16s %s (%0d errors)", test_name, (now == test_base) ? "ok" : "failed",
			now - test_base);
	endtask

	initial begin
		int base;
		arst_n    = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		stall     = 1'b0;
		fast      = 1'b1;
		req_cred  = REQ_CREDITS;
		#5 arst_n = 1'b0;
		repeat (RST_CYC) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		begin_test("reset_state");
		stalled_burst(3);
		end_test();

		begin_test("corner_modes");
		fast = 1'b0;
		for (int m = 0; m < 4; m++) begin
			for (int i = 0; i < 5; i++) begin
				for (int j = 0; j < 5; j++) begin
					issue(corner[i], corner[j], mul_mode_e'(m));
				end
			end
		end
		wait_drain();
		end_test();

		begin_test("random_tags");
		repeat (N_RANDOM) issue_random();
		wait_drain();
		end_test();

		begin_test("back_to_back");
		fast = 1'b1;
		base = n_pulses;
		repeat (4) issue_random();
		wait_drain();
		check_count("request credit pulses", 4, n_pulses - base);
		end_test();

		begin_test("consumer_stall");
		stalled_burst(4);
		end_test();

		begin_test("credit_exhaust");
		stalled_burst(6);
		end_test();

		$display("tests %0d, checker errors %0d, assertion failures %0d", n_tests, errors,
			i_dut.u_props.fail_count);
		if (errors == 0 && i_dut.u_props.fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: tb.f
hdl/mul_cfg_pkg.sv
hdl/mul_types_pkg.sv
hdl/mul_req_intake.sv
hdl/booth_pp_gen.sv
hdl/pp_reduce.sv
hdl/mul_result_queue.sv
hdl/booth_mul_top.sv
verif/booth_mul_properties.sv
verif/tb_booth_mul.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_booth_mul -o tb_booth_mul
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion errors so the testbench reports the outcome
./obj_dir/tb_booth_mul +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" sim.log; then
	echo "failure found in sim.log"
	exit 1
fi

echo "no failure found in sim.log"
exit 0
